// ==== all.f ====
logic/dma_pkg.sv
logic/payload_fifo.sv
logic/burst_splitter.sv
logic/beat_tracker.sv
logic/read_control.sv
logic/dma_read_top.sv
testbench/tb_dma_read.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_dma_read -o sim_dma_read
./obj_dir/sim_dma_read | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== testbench/tb_dma_read.sv ====
`timescale 1ns/1ps

module tb_dma_read;

    typedef struct packed {
        dma_pkg::axi_ar_t req;
        logic             first; // first burst of its command
    } exp_req_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              cmd_valid;
    logic              cmd_ready;
    dma_pkg::dma_cmd_t cmd;
    logic              ar_valid;
    logic              ar_ready;
    dma_pkg::axi_ar_t  ar;
    logic              r_valid;
    logic              r_last;
    logic              busy;
    logic              done;
    logic              error;

    int seed     = 32'h10723fca; // command stimulus
    int bus_seed = 32'h10723fca; // ar_ready and responder gaps

    exp_req_t exp_q[$];
    int       resp_q[$]; // beats of each accepted request
    int       end_q[$];  // running word total at each command end

    int err_count;
    int tests_passed;
    int tests_failed;
    int cmds_sent;
    int done_count;
    int issued;
    int bursts_back;
    int words_sent;
    int words_issued;
    int words_back;
    bit bp_on;
    bit slow;
    bit early_last;
    bit saw_full;
    bit prev_stall;
    int cur_n;
    int cur_i;
    int gap_left;
    dma_pkg::axi_ar_t prev_ar;

    always #50 clk = ~clk;

    dma_read_top i_dma_read_top (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_last    (r_last),
        .busy      (busy),
        .done      (done),
        .error     (error)
    );

    // expected bursts, none crossing a 16-word boundary
    function automatic void split_ref(input int unsigned addr, input int unsigned len);
        int unsigned a;
        int unsigned rem;
        int unsigned n;
        exp_req_t    e;
        a       = addr;
        rem     = len;
        e.first = 1'b1;
        while (rem != 0) begin
            n = dma_pkg::burst_max - (a % dma_pkg::burst_max); // room up to the boundary
            if (n > rem) begin
                n = rem;
            end
            e.req.addr = a[dma_pkg::addr_w-1:0];
            e.req.len  = (dma_pkg::burst_w)'(n - 1);
            exp_q.push_back(e);
            e.first = 1'b0;
            a       = a + n;
            rem     = rem - n;
        end
    endfunction

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic send_cmd(input int unsigned addr, input int unsigned len);
        bit accepted;
        cmd_valid = 1'b1;
        cmd.addr  = addr[dma_pkg::addr_w-1:0];
        cmd.len   = len[dma_pkg::len_w-1:0];
        split_ref(addr, len);
        words_sent += len;
        end_q.push_back(words_sent);
        accepted = 1'b0;
        while (!accepted) begin
            accepted = cmd_ready; // steady until the next rising edge
            @(negedge clk);
        end
        cmd_valid = 1'b0;
        cmds_sent++;
    endtask

    task automatic wait_all_done();
        while (done_count < cmds_sent) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (busy) begin
            $display("error: busy still high after the last done");
            err_count++;
        end
        if (exp_q.size() != 0) begin
            $display("error: %0d expected requests were never issued", exp_q.size());
            err_count++;
        end
    endtask

    task automatic check_error_flag(input bit expected);
        if (error != expected) begin
            $display("FAIL error: got %h expected %h", error, expected);
            err_count++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
        end
    endtask

    // read-address and read-data side of the bus
    always @(negedge clk) begin : bus_driver
        if (rst) begin
            ar_ready = 1'b1;
            r_valid  = 1'b0;
            r_last   = 1'b0;
            cur_n    = 0;
            cur_i    = 0;
            gap_left = 0;
        end else begin
            ar_ready = !bp_on || (($random(bus_seed) & 1) != 0);
            r_valid  = 1'b0;
            r_last   = 1'b0;
            if (cur_n == 0 && resp_q.size() != 0) begin
                cur_n    = resp_q.pop_front();
                cur_i    = 0;
                gap_left = $unsigned($random(bus_seed)) % (slow ? 10 : 3);
            end
            if (cur_n != 0) begin
                if (gap_left != 0) begin
                    gap_left--;
                end else begin
                    r_valid = 1'b1;
                    r_last  = early_last ? (cur_i == cur_n - 2) : (cur_i == cur_n - 1);
                    cur_i++;
                    if (cur_i == cur_n) begin
                        cur_n = 0;
                        bursts_back++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin : compare
        exp_req_t e;
        if (rst) begin
            prev_stall = 1'b0;
        end else begin
            if (prev_stall) begin
                if (!ar_valid) begin
                    $display("error: ar_valid dropped before its transfer");
                    err_count++;
                end else if (ar != prev_ar) begin
                    $display("FAIL ar while stalled: got %h expected %h", ar, prev_ar);
                    err_count++;
                end
            end
            prev_stall = ar_valid && !ar_ready;
            prev_ar    = ar;
            if (ar_valid && ar_ready) begin
                issued++;
                words_issued += int'(ar.len) + 1;
                resp_q.push_back(int'(ar.len) + 1);
                if (exp_q.size() == 0) begin
                    $display("error: request issued with none expected");
                    err_count++;
                end else begin
                    e = exp_q.pop_front();
                    if (ar.addr != e.req.addr) begin
                        $display("FAIL ar.addr: got %h expected %h", ar.addr, e.req.addr);
                        err_count++;
                    end
                    if (ar.len != e.req.len) begin
                        $display("FAIL ar.len: got %h expected %h", ar.len, e.req.len);
                        err_count++;
                    end
                    if (!e.first && ar.addr[dma_pkg::burst_w-1:0] != '0) begin
                        $display("error: later burst at %h is not block aligned", ar.addr);
                        err_count++;
                    end
                end
                if (issued - bursts_back > dma_pkg::max_outstanding) begin
                    $display("error: %0d bursts outstanding", issued - bursts_back);
                    err_count++;
                end
            end
            if (done) begin
                done_count++;
                if (end_q.size() == 0) begin
                    $display("error: done pulse with no command in flight");
                    err_count++;
                end else if (words_back != end_q[0]) begin
                    $display("FAIL words before done: got %h expected %h", words_back, end_q[0]);
                    err_count++;
                    void'(end_q.pop_front());
                end else begin
                    void'(end_q.pop_front());
                end
            end
            if (r_valid) begin
                words_back++;
            end
            if (cmd_valid && !cmd_ready) begin
                saw_full = 1'b1;
            end
        end
    end

    initial begin : main
        int errs;
        int base;
        int unsigned addr;
        int unsigned len;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        ar_ready  = 1'b1;
        r_valid   = 1'b0;
        r_last    = 1'b0;
        apply_reset();

        errs = err_count;
        base = issued;
        send_cmd(32'h40, 16);
        wait_all_done();
        if (issued - base != 1) begin
            $display("error: aligned command gave %0d requests instead of one", issued - base);
            err_count++;
        end
        check_error_flag(1'b0);
        report_test(1, "aligned 16-word command", errs);

        errs = err_count;
        base = issued;
        send_cmd(32'h0d, 20);
        wait_all_done();
        if (issued - base != 3) begin
            $display("error: unaligned command gave %0d requests instead of 3", issued - base);
            err_count++;
        end
        report_test(2, "unaligned command across a boundary", errs);

        errs = err_count;
        base = words_issued;
        addr = $unsigned($random(seed)) % 32'h10_0000;
        send_cmd(addr, 200);
        wait_all_done();
        if (words_issued - base != 200) begin
            $display("FAIL burst beat sum: got %h expected %h", words_issued - base, 200);
            err_count++;
        end
        report_test(3, "long command from a random address", errs);

        errs     = err_count;
        bp_on    = 1'b1;
        slow     = 1'b1;
        saw_full = 1'b0;
        repeat (7) begin
            addr = $unsigned($random(seed)) % 32'h10_0000;
            len  = 48 + $unsigned($random(seed)) % 33;
            send_cmd(addr, len);
        end
        wait_all_done();
        bp_on = 1'b0;
        slow  = 1'b0;
        if (!saw_full) begin
            $display("error: cmd_ready never fell while the command queue was full");
            err_count++;
        end
        report_test(4, "back-pressure and outstanding limit", errs);

        errs = err_count;
        repeat (5) begin
            addr = $unsigned($random(seed)) % 32'h10_0000;
            len  = 1 + $unsigned($random(seed)) % 40;
            send_cmd(addr, len);
        end
        if (!busy) begin
            $display("error: busy low with commands in flight");
            err_count++;
        end
        wait_all_done();
        check_error_flag(1'b0);
        report_test(5, "back-to-back random commands", errs);

        errs       = err_count;
        early_last = 1'b1; // r_last one beat early
        send_cmd(32'h200, 16);
        wait_all_done();
        check_error_flag(1'b1);
        repeat (5) @(negedge clk);
        check_error_flag(1'b1);
        early_last = 1'b0;
        apply_reset();
        check_error_flag(1'b0);
        report_test(6, "early last marker sets sticky error", errs);

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (6 * 2000) @(posedge clk); // six tests
        $display("error: timeout, the run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== logic/dma_read_top.sv ====
`timescale 1ns/1ps

module dma_read_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  dma_pkg::dma_cmd_t cmd,
    output logic              ar_valid,
    input  logic              ar_ready,
    output dma_pkg::axi_ar_t  ar,
    input  logic              r_valid,
    input  logic              r_last,
    output logic              busy,
    output logic              done,
    output logic              error
);

    logic                      cmd_push;
    logic                      cmd_pop;
    logic                      cmd_full;
    logic                      cmd_empty;
    dma_pkg::dma_cmd_t         cmd_head;

    logic                      split_in_ready;
    logic                      split_valid;
    logic                      split_ready;
    logic                      split_last;
    logic [dma_pkg::burst_w:0] split_beats;
    dma_pkg::axi_ar_t          split_ar;

    logic                      issue_ok;
    logic                      issue_gate;
    logic                      ar_fire;

    dma_pkg::burst_rec_t       burst_in;
    dma_pkg::burst_rec_t       burst_head;
    logic                      burst_full;
    logic                      burst_empty;
    logic                      burst_pop;
    logic                      burst_done;
    logic                      burst_cmd_last;
    logic                      last_mismatch;

    assign cmd_ready  = !cmd_full;
    assign cmd_push   = cmd_valid && cmd_ready;
    assign cmd_pop    = !cmd_empty && split_in_ready;

    assign issue_gate = issue_ok && !burst_full;
    assign ar_valid   = split_valid && issue_gate; // held low while issue is blocked
    assign split_ready = ar_ready && issue_gate;
    assign ar         = split_ar;
    assign ar_fire    = ar_valid && ar_ready;
    assign burst_in   = '{beats: split_beats, cmd_last: split_last};

    payload_fifo #(
        .payload_t (dma_pkg::dma_cmd_t),
        .depth     (dma_pkg::cmd_depth)
    ) i_cmd_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (cmd_push),
        .push_data (cmd),
        .pop       (cmd_pop),
        .pop_data  (cmd_head),
        .full      (cmd_full),
        .empty     (cmd_empty)
    );

    burst_splitter i_burst_splitter (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (!cmd_empty),
        .in_ready  (split_in_ready),
        .in_cmd    (cmd_head),
        .out_valid (split_valid),
        .out_ready (split_ready),
        .out_ar    (split_ar),
        .out_last  (split_last),
        .out_beats (split_beats)
    );

    payload_fifo #(
        .payload_t (dma_pkg::burst_rec_t),
        .depth     (dma_pkg::max_outstanding)
    ) i_burst_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (ar_fire),
        .push_data (burst_in),
        .pop       (burst_pop),
        .pop_data  (burst_head),
        .full      (burst_full),
        .empty     (burst_empty)
    );

    beat_tracker i_beat_tracker (
        .clk            (clk),
        .rst            (rst),
        .head           (burst_head),
        .head_valid     (!burst_empty),
        .r_valid        (r_valid),
        .r_last         (r_last),
        .pop            (burst_pop),
        .burst_done     (burst_done),
        .burst_cmd_last (burst_cmd_last),
        .last_mismatch  (last_mismatch)
    );

    read_control i_read_control (
        .clk             (clk),
        .rst             (rst),
        .cmd_push        (cmd_push),
        .cmd_queue_empty (cmd_empty),
        .ar_fire         (ar_fire),
        .burst_done      (burst_done),
        .burst_cmd_last  (burst_cmd_last),
        .last_mismatch   (last_mismatch),
        .issue_ok        (issue_ok),
        .busy            (busy),
        .done            (done),
        .error           (error)
    );

endmodule

// ==== logic/read_control.sv ====
`timescale 1ns/1ps

module read_control (
    input  logic clk,
    input  logic rst,
    input  logic cmd_push,
    input  logic cmd_queue_empty,
    input  logic ar_fire,
    input  logic burst_done,
    input  logic burst_cmd_last,
    input  logic last_mismatch,
    output logic issue_ok,
    output logic busy,
    output logic done,
    output logic error
);

    localparam int ow = dma_pkg::out_cnt_w;
    localparam int cw = dma_pkg::cmd_cnt_w;

    logic [ow-1:0] out_cnt; // bursts issued but not completed
    logic [cw-1:0] cmd_cnt; // commands accepted but not done
    logic          cmd_done;

    assign cmd_done = burst_done && burst_cmd_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_cnt <= '0;
        end else begin
            case ({ar_fire, burst_done})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_cnt <= '0;
        end else begin
            case ({cmd_push, cmd_done})
                2'b10:   cmd_cnt <= cmd_cnt + 1'b1;
                2'b01:   cmd_cnt <= cmd_cnt - 1'b1;
                default: cmd_cnt <= cmd_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            done <= cmd_done;
            if (last_mismatch) begin
                error <= 1'b1; // sticky
            end
        end
    end

    // burst queue depth equals the limit, so this also means the queue has room
    assign issue_ok = (out_cnt < ow'(dma_pkg::max_outstanding));
    assign busy     = (cmd_cnt != '0) || !cmd_queue_empty;

    a_out_limit: assert property (
        @(posedge clk) disable iff (rst) out_cnt <= ow'(dma_pkg::max_outstanding)
    ) else $error("read_control: too many bursts outstanding");

endmodule

// ==== logic/beat_tracker.sv ====
`timescale 1ns/1ps

module beat_tracker (
    input  logic                clk,
    input  logic                rst,
    input  dma_pkg::burst_rec_t head,
    input  logic                head_valid,
    input  logic                r_valid,
    input  logic                r_last,
    output logic                pop,
    output logic                burst_done,
    output logic                burst_cmd_last,
    output logic                last_mismatch
);

    localparam int bw = dma_pkg::burst_w;

    logic [bw:0] beat_cnt; // beats already seen in head burst
    logic [bw:0] beat_num;
    logic        beat_fire;
    logic        is_final;
    logic        final_beat;

    assign beat_num   = beat_cnt + 1'b1;
    assign beat_fire  = r_valid && head_valid;
    assign is_final   = (beat_num == head.beats);
    assign final_beat = beat_fire && is_final;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (beat_fire) begin
            beat_cnt <= is_final ? '0 : beat_num;
        end
    end

    assign pop            = final_beat;
    assign burst_done     = final_beat;
    assign burst_cmd_last = final_beat && head.cmd_last;
    assign last_mismatch  = beat_fire && (r_last != is_final); // bus marker vs count

    // beats only come back for requests already issued
    a_beat_has_burst: assert property (
        @(posedge clk) disable iff (rst) r_valid |-> head_valid
    ) else $error("beat_tracker: read beat with no outstanding burst");

endmodule

// ==== logic/burst_splitter.sv ====
`timescale 1ns/1ps

module burst_splitter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  dma_pkg::dma_cmd_t       in_cmd,
    output logic                    out_valid,
    input  logic                    out_ready,
    output dma_pkg::axi_ar_t        out_ar,
    output logic                    out_last,
    output logic [dma_pkg::burst_w:0] out_beats
);

    localparam int aw = dma_pkg::addr_w;
    localparam int lw = dma_pkg::len_w;
    localparam int bw = dma_pkg::burst_w;

    logic          split_valid;
    logic [aw-1:0] split_addr;
    logic [lw-1:0] split_len;  // words still to issue
    logic [bw:0]   split_inc;  // size of a non-final burst
    logic          split_last;

    logic [aw-1:0] next_addr;
    logic [lw-1:0] next_len;
    logic [bw:0]   next_inc;
    logic [bw:0]   beats_m1;

    assign in_ready   = !split_valid;
    assign split_last = (split_len <= lw'(split_inc));

    always_comb begin
        if (!split_valid) begin
            next_addr = in_cmd.addr;
            next_len  = in_cmd.len;
            next_inc  = (bw + 1)'(dma_pkg::burst_max) - {1'b0, in_cmd.addr[bw-1:0]}; // up to boundary
        end else begin
            next_addr = {split_addr[aw-1:bw] + 1'b1, {bw{1'b0}}}; // next aligned block
            next_len  = split_len - lw'(split_inc);
            next_inc  = (bw + 1)'(dma_pkg::burst_max);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            split_valid <= 1'b0;
        end else begin
            if (out_ready && split_last) begin
                split_valid <= 1'b0;
            end
            if (in_valid && in_ready) begin
                split_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!split_valid || out_ready) begin
            split_addr <= next_addr;
            split_len  <= next_len;
            split_inc  <= next_inc;
        end
    end

    assign out_valid = split_valid;
    assign out_last  = split_last;
    assign out_beats = split_last ? split_len[bw:0] : split_inc;
    assign beats_m1  = out_beats - 1'b1;

    always_comb begin
        out_ar.addr = split_addr;
        out_ar.len  = beats_m1[bw-1:0]; // AXI beats minus one
    end

    a_ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_ar))
    ) else $error("burst_splitter: request changed while stalled");

endmodule

// ==== logic/payload_fifo.sv ====
`timescale 1ns/1ps

module payload_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic [cnt_w-1:0]   next_count;

    assign next_count = count + cnt_w'(push) - cnt_w'(pop);
    assign pop_data   = mem[rd_ptr]; // head entry

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b1; // not ready until out of reset
            empty  <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= next_count;
            full  <= (next_count == cnt_w'(depth));
            empty <= (next_count == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // callers must respect the flags
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    ) else $error("payload_fifo: push while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> !empty
    ) else $error("payload_fifo: pop while empty");

endmodule

// ==== logic/dma_pkg.sv ====
package dma_pkg;

    localparam int addr_w          = 30;
    localparam int len_w           = 16; // must exceed burst_w
    localparam int burst_w         = 4;
    localparam int burst_max       = 1 << burst_w;
    localparam int max_outstanding = 4;
    localparam int cmd_depth       = 4;

    // counter widths for read_control
    localparam int out_cnt_w       = $clog2(max_outstanding + 1);
    localparam int cmd_cnt_w       = 8; // room for queued, splitting and draining commands

    // software command, len in words, never zero
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
    } dma_cmd_t;

    // read-address request, len is beats minus one
    typedef struct packed {
        logic [addr_w-1:0]  addr;
        logic [burst_w-1:0] len;
    } axi_ar_t;

    // one outstanding burst waiting for its beats
    typedef struct packed {
        logic [burst_w:0] beats;
        logic             cmd_last;
    } burst_rec_t;

endpackage
